/* verif/cpu_golden.txt */
# tag addr data, all hex
# tag 0 program word, tag 1 expected word after hlt, tag 2 final pc in the data column
0 0000 A105
0 0002 BF01
0 0004 A2FF
0 0006 B27F
0 0008 0321
0 000A CC01
0 000C A4BB
0 000E 93F0
0 0010 94F1
0 0012 1511
0 0014 C201
0 0016 A599
0 0018 95F2
0 001A 1612
0 001C C201
0 001E A73C
0 0020 C601
0 0022 A766
0 0024 2821
0 0026 3926
0 0028 4A16
0 002A 5B11
0 002C 7C61
0 002E 6D61
0 0030 96F3
0 0032 97F4
0 0034 98F5
0 0036 99F6
0 0038 9AF7
0 003A 9BFF
0 003C 9CFE
0 003E 9DFD
0 0040 8EFF
0 0042 E400
0 0044 0011
0 0046 0EE0
0 0048 94FC
0 004A 9EFB
0 004C CE01
0 004E F000
0 0050 83F3
0 0052 93FA
0 0054 F000
# add overflow sum, then the ov branch skips llb r4
1 0100 8004
1 0102 0000
# sub to zero, eq branch skips llb r5
1 0104 0000
1 0106 8006
# not taken eq then taken lt keeps 3c
1 0108 003C
1 010A 7FFA
1 010C 0006
1 010E 8007
1 00FE 00A0
1 00FC FC00
1 00FA 0400
# pcs link value
1 00F8 0044
1 00F6 00A0
# lw with positive offset after the always branch
1 00F4 8006
2 0000 0054

/* src.f */
+incdir+include
verilog/isa_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/cpu_core.sv
verilog/wb_arbiter.sv
verilog/wb_ram.sv
verilog/cpu_subsystem.sv
verif/cpu_monitor.sv
verif/cpu_sva.sv
verif/tb_cpu.sv

/* run_sim.sh */
#!/bin/bash
# build with verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_cpu -f src.f -o sim_cpu > build.log 2>&1 &&
./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import isa_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        run;
  wb_req_t     host_req;
  wb_rsp_t     host_rsp;
  logic        hlt;
  logic [15:0] pc;
  logic        final_check;
  int          errors;
  int          checks;
  logic        final_done;

  logic [15:0] prog_adr [$];
  logic [15:0] prog_dat [$];
  logic [15:0] exp_adr [$];
  int          n_lines;
  integer      fd;
  integer      code;
  string       line;
  logic [15:0] tag;
  logic [15:0] adr;
  logic [15:0] dat;
  int          gap;
  int          idx;

  cpu_subsystem dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .hlt      (hlt),
    .pc       (pc)
  );

  cpu_monitor u_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .core_cyc    (dut.core_req.cyc),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .hlt         (hlt),
    .pc          (pc),
    .final_check (final_check),
    .errors      (errors),
    .checks      (checks),
    .final_done  (final_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one host bus cycle, request dropped on the edge that sees ack
  task automatic host_access(input logic we, input logic [15:0] a, input logic [15:0] d);
    @(posedge clk);
    host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat: d};
    do @(posedge clk); while (!host_rsp.ack);
    host_req <= '0;
  endtask

  // 200 cycles per golden line, counted once reset is released
  initial begin
    wait (rst_n === 1'b1);
    repeat (n_lines * 200) @(posedge clk);
    $display("watchdog expired before the test sequence finished, %0d errors so far", errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    run         = 1'b0;
    host_req    = '0;
    final_check = 1'b0;
    n_lines     = 0;
    void'($urandom(32'h3a4f_d77d));
    fd = $fopen("verif/cpu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%h %h %h", tag, adr, dat) == 3) begin
          n_lines = n_lines + 1;
          if (tag == 16'h0) begin
            prog_adr.push_back(adr);
            prog_dat.push_back(dat);
          end else if (tag == 16'h1) begin
            exp_adr.push_back(adr);
          end
        end
      end
      $fclose(fd);
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      // load with the core idle, then read it all back
      foreach (prog_adr[i]) host_access(1'b1, prog_adr[i], prog_dat[i]);
      foreach (prog_adr[i]) host_access(1'b0, prog_adr[i], 16'h0);
      @(posedge clk);
      run <= 1'b1;
      // host contends with the running core
      while (!hlt) begin
        gap = int'($urandom % 32'd4);
        repeat (gap) @(posedge clk);
        idx = int'($urandom % 32'(prog_adr.size()));
        host_access(1'b0, prog_adr[idx], 16'h0);
      end
      foreach (exp_adr[i]) host_access(1'b0, exp_adr[i], 16'h0);
      @(posedge clk);
      final_check <= 1'b1;
      wait (final_done);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* include/wb_defs.svh */
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// bus timing bounds for the shared wishbone classic bus

// the ram acks one cycle after it first sees stb
// a master that is not granted keeps stb high while the other master finishes
// so the bound covers one full foreign cycle plus our own
// measured from the first cycle with stb high to the cycle with ack high
`define WB_ACK_MAX 4

// core fetch, load and store all go through the same arbiter
// host accesses see the same bound

`endif

/* verif/cpu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module cpu_sva (
  input logic             clk,
  input logic             rst_n,
  input isa_pkg::wb_req_t m0_req,
  input isa_pkg::wb_req_t m1_req,
  input isa_pkg::wb_rsp_t m0_rsp,
  input isa_pkg::wb_rsp_t m1_rsp,
  input logic             grant
);

  // cycles each master has spent with stb high and no ack
  int   m0_wait;
  int   m1_wait;
  // grant and the granted master's cyc as of the last edge
  logic grant_q;
  logic granted_cyc_q;
  logic granted_cyc;

  assign granted_cyc = grant ? m1_req.cyc : m0_req.cyc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m0_wait       <= 0;
      m1_wait       <= 0;
      grant_q       <= 1'b0;
      granted_cyc_q <= 1'b0;
    end else begin
      m0_wait       <= (!m0_req.stb || m0_rsp.ack) ? 0 : m0_wait + 1;
      m1_wait       <= (!m1_req.stb || m1_rsp.ack) ? 0 : m1_wait + 1;
      grant_q       <= grant;
      granted_cyc_q <= granted_cyc;
    end
  end

  // an ack only reaches a master that has its request up
  ack_to_m0: assert property (@(posedge clk) disable iff (!rst_n)
    m0_rsp.ack |-> (m0_req.cyc && m0_req.stb))
    else $error("core got an ack with no request up");

  ack_to_m1: assert property (@(posedge clk) disable iff (!rst_n)
    m1_rsp.ack |-> (m1_req.cyc && m1_req.stb))
    else $error("host got an ack with no request up");

  // granted master keeps the grant while its cyc stays high
  grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    (granted_cyc_q && (grant_q ? m1_req.cyc : m0_req.cyc)) |-> (grant == grant_q))
    else $error("grant moved while the owner held cyc");

  ack_bound_m0: assert property (@(posedge clk) disable iff (!rst_n)
    m0_req.stb |-> (m0_wait < `WB_ACK_MAX))
    else $error("core waited too long for ack");

  ack_bound_m1: assert property (@(posedge clk) disable iff (!rst_n)
    m1_req.stb |-> (m1_wait < `WB_ACK_MAX))
    else $error("host waited too long for ack");

  // address held until the ack arrives
  adr_hold_m0: assert property (@(posedge clk) disable iff (!rst_n)
    (m0_req.stb && !m0_rsp.ack) |=> $stable(m0_req.adr))
    else $error("core changed adr before ack");

  adr_hold_m1: assert property (@(posedge clk) disable iff (!rst_n)
    (m1_req.stb && !m1_rsp.ack) |=> $stable(m1_req.adr))
    else $error("host changed adr before ack");

endmodule

bind wb_arbiter cpu_sva u_sva (
  .clk    (clk),
  .rst_n  (rst_n),
  .m0_req (m0_req),
  .m1_req (m1_req),
  .m0_rsp (m0_rsp),
  .m1_rsp (m1_rsp),
  .grant  (grant)
);

`default_nettype wire

/* verif/cpu_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_monitor (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  logic             core_cyc,
  input  isa_pkg::wb_req_t host_req,
  input  isa_pkg::wb_rsp_t host_rsp,
  input  logic             hlt,
  input  logic [15:0]      pc,
  input  logic             final_check,
  output int               errors,
  output int               checks,
  output logic             final_done
);
  import isa_pkg::*;

  logic [15:0] prog_map [logic [15:0]];
  logic [15:0] exp_map [logic [15:0]];
  logic [15:0] exp_pc;
  integer      fd;
  integer      code;
  string       line;
  logic [15:0] tag;
  logic [15:0] adr;
  logic [15:0] dat;

  // same golden file as the driver
  initial begin
    exp_pc = '0;
    fd = $fopen("verif/cpu_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%h %h %h", tag, adr, dat) == 3) begin
          if (tag == 16'h0) prog_map[adr] = dat;
          else if (tag == 16'h1) exp_map[adr] = dat;
          else exp_pc = dat;
        end
      end
      $fclose(fd);
    end
  end

  // compare a read word against its golden value
  task automatic compare_word(input logic [15:0] a, input logic [15:0] want,
                              input logic [15:0] got);
    checks = checks + 1;
    if (got !== want) begin
      errors = errors + 1;
      $display("FAILED at %0t: host_rsp.dat at %h expected %h got %h", $time, a, want, got);
    end
  endtask

  // all inputs sampled as they were before the edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      errors     = 0;
      checks     = 0;
      final_done = 1'b0;
    end else begin
      if (!run && core_cyc) begin
        errors = errors + 1;
        $display("core requested the bus while run was low at %0t", $time);
      end
      if (host_rsp.ack) begin
        if (!(host_req.cyc && host_req.stb)) begin
          errors = errors + 1;
          $display("unexpected ack with no request pending at %0t", $time);
        end else if (!host_req.we) begin
          // data words count only once the core has halted
          if (hlt && exp_map.exists(host_req.adr)) begin
            compare_word(host_req.adr, exp_map[host_req.adr], host_rsp.dat);
          end else if (prog_map.exists(host_req.adr)) begin
            compare_word(host_req.adr, prog_map[host_req.adr], host_rsp.dat);
          end else begin
            errors = errors + 1;
            $display("host read of %h has no expected value", host_req.adr);
          end
        end
      end
      if (final_check && !final_done) begin
        checks = checks + 1;
        if (!hlt) begin
          errors = errors + 1;
          $display("hlt never rose");
        end
        if (pc !== exp_pc) begin
          errors = errors + 1;
          $display("FAILED at %0t: pc expected %h got %h", $time, exp_pc, pc);
        end
        final_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/cpu_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_subsystem (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  isa_pkg::wb_req_t host_req,
  output isa_pkg::wb_rsp_t host_rsp,
  output logic             hlt,
  output logic [15:0]      pc
);
  import isa_pkg::*;

  // core side of the arbiter
  wb_req_t core_req;
  wb_rsp_t core_rsp;
  // shared slave side
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;

  cpu_core u_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .bus_req (core_req),
    .bus_rsp (core_rsp),
    .hlt     (hlt),
    .pc      (pc)
  );

  // core is m0, host is m1
  wb_arbiter u_arb (
    .clk    (clk),
    .rst_n  (rst_n),
    .m0_req (core_req),
    .m1_req (host_req),
    .m0_rsp (core_rsp),
    .m1_rsp (host_rsp),
    .s_req  (ram_req),
    .s_rsp  (ram_rsp)
  );

  // program and data share this ram
  wb_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

endmodule

`default_nettype wire

/* verilog/wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
  input  logic             clk,
  input  logic             rst_n,
  input  isa_pkg::wb_req_t req,
  output isa_pkg::wb_rsp_t rsp
);
  import isa_pkg::*;

  logic [15:0]                  mem [mem_words];
  logic [$clog2(mem_words)-1:0] word_adr;
  logic                         ack_q;
  logic [15:0]                  rd_q;
  logic                         access;

  // byte address, bit 0 dropped
  assign word_adr = req.adr[$clog2(mem_words):1];
  // new request, not yet acked
  assign access   = req.cyc && req.stb && !ack_q;

  // single cycle ack, low again while the master drops stb
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (req.we) mem[word_adr] <= req.dat;
      // read data lines up with ack
      rd_q <= mem[word_adr];
    end
  end

  assign rsp.ack = ack_q;
  assign rsp.dat = rd_q;

endmodule

`default_nettype wire

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic             clk,
  input  logic             rst_n,
  input  isa_pkg::wb_req_t m0_req,
  input  isa_pkg::wb_req_t m1_req,
  output isa_pkg::wb_rsp_t m0_rsp,
  output isa_pkg::wb_rsp_t m1_rsp,
  output isa_pkg::wb_req_t s_req,
  input  isa_pkg::wb_rsp_t s_rsp
);

  // owned and owner describe the bus as of the last edge
  logic owned;
  logic owner;
  // master granted at the most recent new grant
  logic last_served;
  logic owner_cyc;
  logic hold;
  logic grant;
  logic grant_cyc;

  assign owner_cyc = owner ? m1_req.cyc : m0_req.cyc;
  // owner keeps the bus for as long as its cyc is high
  assign hold      = owned && owner_cyc;

  always_comb begin
    if (hold) begin
      grant = owner;
    end else if (m0_req.cyc && m1_req.cyc) begin
      // contention goes to the master not served last
      grant = ~last_served;
    end else begin
      grant = m1_req.cyc;
    end
  end

  assign grant_cyc = grant ? m1_req.cyc : m0_req.cyc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owned       <= 1'b0;
      owner       <= 1'b0;
      last_served <= 1'b0;
    end else begin
      owned <= grant_cyc;
      owner <= grant;
      // only a fresh grant moves the round robin pointer
      if (!hold && grant_cyc) last_served <= grant;
    end
  end

  // slave sees the granted master only
  assign s_req  = grant ? m1_req : m0_req;
  // the waiting master sees nothing back
  assign m0_rsp = grant ? '0 : s_rsp;
  assign m1_rsp = grant ? s_rsp : '0;

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  output isa_pkg::wb_req_t bus_req,
  input  isa_pkg::wb_rsp_t bus_rsp,
  output logic             hlt,
  output logic [15:0]      pc
);
  import isa_pkg::*;

  typedef enum logic [2:0] {st_idle, st_fetch, st_execute, st_mem, st_halt} state_t;

  state_t      state;
  logic [15:0] pc_q;
  instr_u      ir;
  logic [15:0] mdr;
  // set once the data access of lw or sw has been acked
  logic        mem_done;

  logic [3:0]  op;
  logic        is_alu, is_shift, is_lw, is_sw, is_llb, is_lhb;
  logic        is_br, is_pcs, is_hlt, is_mem;
  logic [3:0]  rs_sel;
  logic [3:0]  rt_sel;
  logic [15:0] rs_data, rt_data, alu_result, wr_data;
  logic [15:0] mem_addr, pc_plus2, br_target;
  flags_t      alu_flags, flags_in, flags;
  logic        writeback, wr_en, flag_en, cond_met, taken;

  // decode
  assign op       = ir.r_form.opcode;
  assign is_alu   = ~op[3];
  assign is_shift = (op == op_sll) || (op == op_srl) || (op == op_sra);
  assign is_lw    = (op == op_lw);
  assign is_sw    = (op == op_sw);
  assign is_llb   = (op == op_llb);
  assign is_lhb   = (op == op_lhb);
  assign is_br    = (op == op_br);
  assign is_pcs   = (op == op_pcs);
  assign is_hlt   = (op == op_hlt);
  assign is_mem   = is_lw || is_sw;

  // byte loads read the old rd, stores read rd as data
  assign rs_sel = (is_llb || is_lhb) ? ir.i_form.rd : ir.r_form.rs;
  assign rt_sel = is_sw ? ir.r_form.rd : ir.r_form.rt;

  register_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs_sel   (rs_sel),
    .rt_sel   (rt_sel),
    .rd_sel   (ir.r_form.rd),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .flag_en  (flag_en),
    .flags_in (flags_in),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .flags    (flags)
  );

  alu u_alu (
    .a      (rs_data),
    .b      (rt_data),
    .op     (op),
    .result (alu_result),
    .flags  (alu_flags)
  );

  // rs plus twice the signed 4 bit word offset
  assign mem_addr  = rs_data + {{11{ir.r_form.rt[3]}}, ir.r_form.rt, 1'b0};
  assign pc_plus2  = pc_q + 16'd2;
  assign br_target = pc_plus2 + {{6{ir.b_form.off9[8]}}, ir.b_form.off9, 1'b0};

  always_comb begin
    case (ir.b_form.cond)
      cc_ne:   cond_met = ~flags.z;
      cc_eq:   cond_met = flags.z;
      cc_gt:   cond_met = ~flags.z && ~flags.n;
      cc_lt:   cond_met = flags.n;
      cc_ge:   cond_met = flags.z || ~flags.n;
      cc_le:   cond_met = flags.z || flags.n;
      cc_ov:   cond_met = flags.v;
      cc_al:   cond_met = 1'b1;
      default: cond_met = 1'b0;
    endcase
  end
  assign taken = is_br && cond_met;

  // last cycle of every instruction, after its final ack
  assign writeback = (state == st_execute) && (!is_mem || mem_done);
  assign wr_en     = writeback && (is_alu || is_lw || is_llb || is_lhb || is_pcs);
  assign flag_en   = writeback && is_alu;
  // shifts keep the old v
  assign flags_in  = '{z: alu_flags.z, n: alu_flags.n, v: is_shift ? flags.v : alu_flags.v};

  always_comb begin
    if (is_lw) wr_data = mdr;
    else if (is_llb) wr_data = {rs_data[15:8], ir.i_form.imm8};
    else if (is_lhb) wr_data = {ir.i_form.imm8, rs_data[7:0]};
    else if (is_pcs) wr_data = pc_plus2;
    else wr_data = alu_result;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      pc_q     <= '0;
      mem_done <= 1'b0;
    end else begin
      case (state)
        st_idle: if (run) state <= st_fetch;
        st_fetch: begin
          if (bus_rsp.ack) begin
            mem_done <= 1'b0;
            state    <= st_execute;
          end
        end
        st_execute: begin
          // pc stays on the hlt address
          if (is_hlt) begin
            state <= st_halt;
          end else if (is_mem && !mem_done) begin
            state <= st_mem;
          end else begin
            pc_q  <= taken ? br_target : pc_plus2;
            state <= st_fetch;
          end
        end
        st_mem: begin
          if (bus_rsp.ack) begin
            mem_done <= 1'b1;
            state    <= st_execute;
          end
        end
        st_halt: state <= st_halt;
        default: state <= st_idle;
      endcase
    end
  end

  // instruction and load data latched on ack
  always_ff @(posedge clk) begin
    if ((state == st_fetch) && bus_rsp.ack) ir <= bus_rsp.dat;
    if ((state == st_mem) && bus_rsp.ack) mdr <= bus_rsp.dat;
  end

  // request held from state, drops the cycle after ack
  always_comb begin
    bus_req.cyc = (state == st_fetch) || (state == st_mem);
    bus_req.stb = (state == st_fetch) || (state == st_mem);
    bus_req.we  = (state == st_mem) && is_sw;
    bus_req.adr = (state == st_mem) ? mem_addr : pc_q;
    bus_req.dat = rt_data;
  end

  assign hlt = (state == st_halt);
  assign pc  = pc_q;

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [3:0]      rs_sel,
  input  logic [3:0]      rt_sel,
  input  logic [3:0]      rd_sel,
  input  logic            wr_en,
  input  logic [15:0]     wr_data,
  input  logic            flag_en,
  input  isa_pkg::flags_t flags_in,
  output logic [15:0]     rs_data,
  output logic [15:0]     rt_data,
  output isa_pkg::flags_t flags
);

  logic [15:0] regs [16];

  // r0 is hardwired to zero on both read ports
  assign rs_data = (rs_sel == 4'd0) ? 16'd0 : regs[rs_sel];
  assign rt_data = (rt_sel == 4'd0) ? 16'd0 : regs[rt_sel];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (rd_sel != 4'd0)) begin
      // writes to r0 are dropped
      regs[rd_sel] <= wr_data;
    end
  end

  // z, n, v held between compute instructions for branches
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flag_en) begin
      flags <= flags_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [15:0]     a,
  input  logic [15:0]     b,
  input  logic [3:0]      op,
  output logic [15:0]     result,
  output isa_pkg::flags_t flags
);
  import isa_pkg::*;

  logic [15:0] sum;
  logic [15:0] diff;
  logic        v;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    result = '0;
    v      = 1'b0;
    case (op)
      op_add: begin
        result = sum;
        // same sign in, other sign out
        v = (a[15] == b[15]) && (sum[15] != a[15]);
      end
      op_sub: begin
        result = diff;
        // signs differ and result flips away from a
        v = (a[15] != b[15]) && (diff[15] != a[15]);
      end
      op_xor: result = a ^ b;
      op_and: result = a & b;
      op_or:  result = a | b;
      // shift amount is the low nibble of b
      op_sll: result = a << b[3:0];
      op_srl: result = a >> b[3:0];
      op_sra: result = 16'($signed(a) >>> b[3:0]);
      default: result = '0;
    endcase
  end

  // z and n straight from the result
  assign flags.z = (result == 16'd0);
  assign flags.n = result[15];
  assign flags.v = v;

endmodule

`default_nettype wire

/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // unified word ram size
  localparam int mem_words = 256;

  // compute opcodes, all with opcode[3] low
  localparam logic [3:0] op_add = 4'h0;
  localparam logic [3:0] op_sub = 4'h1;
  localparam logic [3:0] op_xor = 4'h2;
  localparam logic [3:0] op_and = 4'h3;
  localparam logic [3:0] op_or  = 4'h4;
  localparam logic [3:0] op_sll = 4'h5;
  localparam logic [3:0] op_srl = 4'h6;
  localparam logic [3:0] op_sra = 4'h7;
  // memory, immediate and control opcodes
  localparam logic [3:0] op_lw  = 4'h8;
  localparam logic [3:0] op_sw  = 4'h9;
  localparam logic [3:0] op_llb = 4'ha;
  localparam logic [3:0] op_lhb = 4'hb;
  localparam logic [3:0] op_br  = 4'hc;
  localparam logic [3:0] op_pcs = 4'he;
  localparam logic [3:0] op_hlt = 4'hf;

  // branch conditions
  localparam logic [2:0] cc_ne = 3'd0;
  localparam logic [2:0] cc_eq = 3'd1;
  localparam logic [2:0] cc_gt = 3'd2;
  localparam logic [2:0] cc_lt = 3'd3;
  localparam logic [2:0] cc_ge = 3'd4;
  localparam logic [2:0] cc_le = 3'd5;
  localparam logic [2:0] cc_ov = 3'd6;
  localparam logic [2:0] cc_al = 3'd7;

  // alu, lw and sw, rt doubles as the signed word offset for memory
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } r_form_t;

  // llb and lhb
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } i_form_t;

  // conditional branch, off9 is a signed word offset from pc+2
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;
    logic [8:0] off9;
  } b_form_t;

  // one instruction word seen three ways
  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
    b_form_t b_form;
  } instr_u;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  // master to slave, adr is a byte address
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [15:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire
